/* src/pixel_fetch_pkg.sv */
/*
 * Pixel fetch shared definitions
 * Widths, beat geometry, vector types and the structs that travel
 * between the request, queue and select stages
 */
package pixel_fetch_pkg;

    // Bus and pixel geometry
    localparam int ADDR_WIDTH    = 32;
    localparam int STREAM_WIDTH  = 32;
    localparam int PIXEL_WIDTH   = 16;
    localparam int PIX_PER_BEAT  = 2;
    localparam int SLOT_WIDTH    = 1;
    localparam int BEAT_BYTES_LG = 2;
    localparam int TAG_WIDTH     = ADDR_WIDTH - SLOT_WIDTH;

    // Fragment queue sizing
    localparam int QUEUE_DEPTH   = 8;
    localparam int PTR_WIDTH     = $clog2(QUEUE_DEPTH);
    localparam int COUNT_WIDTH   = $clog2(QUEUE_DEPTH + 1);

    typedef logic [ADDR_WIDTH - 1 : 0]   addr_t;
    typedef logic [ADDR_WIDTH - 1 : 0]   pix_index_t;
    typedef logic [TAG_WIDTH - 1 : 0]    tag_t;
    typedef logic [SLOT_WIDTH - 1 : 0]   slot_t;
    typedef logic [STREAM_WIDTH - 1 : 0] beat_t;
    typedef logic [PIXEL_WIDTH - 1 : 0]  pixel_t;

    typedef struct packed {
        pix_index_t index;
        logic       last;
    } frag_t;

    typedef struct packed {
        slot_t slot;
        logic  new_line;
        logic  last;
    } queue_entry_t;

    typedef struct packed {
        pixel_t pixel;
        logic   last;
    } pixel_out_t;

    typedef enum logic {IDLE, SKID} req_state_t;

endpackage

/* src/fetch_request_gen.sv */
/*
 * Fetch request generator
 * Compares the beat tag of each fragment with the previous one and
 * issues one read address per new line. A conflicting fragment waits
 * in a skid register while a request is still pending.
 */
`timescale 1ns/1ps

module fetch_request_gen import pixel_fetch_pkg::*;
(
    input  logic         aclk,
    input  logic         resetn,
    input  addr_t        conf_addr,
    input  frag_t        frag,
    input  logic         frag_valid,
    output logic         frag_ready,
    output addr_t        ar_addr,
    output logic         ar_valid,
    input  logic         ar_ready,
    output logic         push,
    output queue_entry_t push_entry,
    input  logic         queue_full
);

    req_state_t state;
    tag_t       last_tag;
    tag_t       frag_tag;
    slot_t      frag_slot;
    logic       new_line;
    logic       accept;
    // Skid register for a fragment that needs a line while one is pending
    tag_t       skid_tag;
    slot_t      skid_slot;
    logic       skid_last;
    // Pending request between acceptance and the address stage
    logic       mem_request;
    tag_t       req_tag;
    logic       req_set;
    logic       req_take;
    addr_t      line_offset;

    // Split index into beat tag and pixel slot
    assign frag_tag  = frag.index[SLOT_WIDTH +: TAG_WIDTH];
    assign frag_slot = frag.index[SLOT_WIDTH - 1 : 0];
    assign new_line  = frag_tag != last_tag;

    // No acceptance while parked in skid or queue has no room
    assign frag_ready = (state == IDLE) && !queue_full;
    assign accept     = frag_valid && frag_ready;

    // New request from a fresh fragment or from the skid register
    assign req_set  = !mem_request &&
                      ((state == SKID) || (accept && new_line));
    // Pending request moves on once the address stage is idle
    assign req_take = mem_request && !ar_valid;

    assign line_offset = addr_t'(req_tag) << BEAT_BYTES_LG;

    ////////////////////////////////////////
    // Fragment acceptance
    ////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state    <= IDLE;
            last_tag <= '1;
            push     <= 1'b0;
        end
        else
        begin
            push <= 1'b0;
            case (state)
                IDLE:
                begin
                    if (accept)
                    begin
                        if (new_line && mem_request)
                        begin
                            // Request slot busy, park the fragment
                            state <= SKID;
                        end
                        else
                        begin
                            push     <= 1'b1;
                            // Last fragment of a packet forces a fresh fetch
                            last_tag <= frag.last ? '1 : frag_tag;
                        end
                    end
                end
                SKID:
                begin
                    if (!mem_request)
                    begin
                        push     <= 1'b1;
                        state    <= IDLE;
                        last_tag <= skid_last ? '1 : skid_tag;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload side of acceptance and the request tag
    always_ff @(posedge aclk)
    begin
        if ((state == IDLE) && accept)
        begin
            skid_tag   <= frag_tag;
            skid_slot  <= frag_slot;
            skid_last  <= frag.last;
            push_entry <= '{slot: frag_slot, new_line: new_line, last: frag.last};
        end
        else if (state == SKID)
        begin
            // Skid fragment always opens a line
            push_entry <= '{slot: skid_slot, new_line: 1'b1, last: skid_last};
        end
        if (req_set)
        begin
            req_tag <= (state == SKID) ? skid_tag : frag_tag;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
            mem_request <= 1'b0;
        else if (req_set)
            mem_request <= 1'b1;
        else if (req_take)
            mem_request <= 1'b0;
    end

    ////////////////////////////////////////
    // Read address stage
    ////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            ar_valid <= 1'b0;
        end
        else if (!ar_valid)
        begin
            if (mem_request)
                ar_valid <= 1'b1;
        end
        else if (ar_ready)
        begin
            ar_valid <= 1'b0;
        end
    end

    // Address only loads while the channel is idle so it holds until ready
    always_ff @(posedge aclk)
    begin
        if (req_take)
            ar_addr <= conf_addr + line_offset;
    end

endmodule

/* src/fragment_queue.sv */
/*
 * Fragment queue
 * Circular buffer that keeps fragment order and slot information
 * between request issue and read data return
 */
`timescale 1ns/1ps

module fragment_queue import pixel_fetch_pkg::*;
(
    input  logic         aclk,
    input  logic         resetn,
    input  logic         push,
    input  queue_entry_t push_entry,
    output logic         full,
    output queue_entry_t head,
    output logic         head_valid,
    input  logic         pop
);

    queue_entry_t             mem [QUEUE_DEPTH];
    logic [PTR_WIDTH - 1 : 0] wr_ptr;
    logic [PTR_WIDTH - 1 : 0] rd_ptr;
    logic [COUNT_WIDTH - 1 : 0] count;
    logic                     do_push;
    logic                     do_pop;

    assign head       = mem[rd_ptr];
    assign head_valid = count != '0;

    // One entry held back, the producer pushes a cycle after it accepts
    assign full = count >= COUNT_WIDTH'(QUEUE_DEPTH - 1);

    assign do_push = push && (count != COUNT_WIDTH'(QUEUE_DEPTH));
    assign do_pop  = pop && head_valid;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Occupancy only moves when exactly one side is active
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge aclk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_entry;
    end

endmodule

/* src/pixel_select.sv */
/*
 * Pixel selector
 * Latches read beats into a line register and picks one pixel per
 * queued fragment, keeping the packet last flag
 */
`timescale 1ns/1ps

module pixel_select import pixel_fetch_pkg::*;
(
    input  logic         aclk,
    input  logic         resetn,
    input  queue_entry_t head,
    input  logic         head_valid,
    output logic         pop,
    input  beat_t        r_data,
    input  logic         r_valid,
    output logic         r_ready,
    output pixel_out_t   pixel,
    output logic         pixel_valid,
    input  logic         pixel_ready
);

    beat_t                           line_q;
    beat_t                           src_beat;
    pixel_t [PIX_PER_BEAT - 1 : 0]   pix_lane;
    logic                            out_free;

    // Output register can take a new pixel
    assign out_free = !pixel_valid || pixel_ready;

    ////////////////////////////////////////
    // Queue and read data handshakes
    ////////////////////////////////////////

    // Beats only taken for a head that opens a new line
    assign r_ready = head_valid && head.new_line && out_free;

    // New line head waits for its beat, others use the held line
    assign pop = head_valid && out_free && (!head.new_line || r_valid);

    // Incoming beat bypasses the line register on a new line
    assign src_beat = head.new_line ? r_data : line_q;
    assign pix_lane = src_beat;

    ////////////////////////////////////////
    // Line and output registers
    ////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (pop && head.new_line)
            line_q <= r_data;
        if (pop)
        begin
            pixel.pixel <= pix_lane[head.slot];
            pixel.last  <= head.last;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            pixel_valid <= 1'b0;
        end
        else if (pop)
        begin
            pixel_valid <= 1'b1;
        end
        else if (pixel_ready)
        begin
            // Pixel taken and nothing new behind it
            pixel_valid <= 1'b0;
        end
    end

endmodule

/* src/pixel_fetch_top.sv */
/*
 * Pixel fetch unit
 * Request generator, fragment queue and pixel selector in a chain
 * between the fragment stream, the read channels and the pixel output
 */
`timescale 1ns/1ps

module pixel_fetch_top import pixel_fetch_pkg::*;
(
    input  logic       aclk,
    input  logic       resetn,
    input  addr_t      conf_addr,
    input  frag_t      frag,
    input  logic       frag_valid,
    output logic       frag_ready,
    output addr_t      ar_addr,
    output logic       ar_valid,
    input  logic       ar_ready,
    input  beat_t      r_data,
    input  logic       r_valid,
    output logic       r_ready,
    output pixel_out_t pixel,
    output logic       pixel_valid,
    input  logic       pixel_ready
);

    // Queue push side
    logic         push;
    queue_entry_t push_entry;
    logic         queue_full;
    // Queue head side
    queue_entry_t head;
    logic         head_valid;
    logic         pop;

    fetch_request_gen fetch_request_gen_i (
        .aclk       (aclk),
        .resetn     (resetn),
        .conf_addr  (conf_addr),
        .frag       (frag),
        .frag_valid (frag_valid),
        .frag_ready (frag_ready),
        .ar_addr    (ar_addr),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .push       (push),
        .push_entry (push_entry),
        .queue_full (queue_full)
    );

    fragment_queue fragment_queue_i (
        .aclk       (aclk),
        .resetn     (resetn),
        .push       (push),
        .push_entry (push_entry),
        .full       (queue_full),
        .head       (head),
        .head_valid (head_valid),
        .pop        (pop)
    );

    pixel_select pixel_select_i (
        .aclk        (aclk),
        .resetn      (resetn),
        .head        (head),
        .head_valid  (head_valid),
        .pop         (pop),
        .r_data      (r_data),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready)
    );

endmodule

/* test/pixel_fetch_sva.sv */
/*
 * Pixel fetch handshake checker
 * Bound to the top level, watches the read-address and pixel outputs
 */
`timescale 1ns/1ps

module pixel_fetch_sva import pixel_fetch_pkg::*;
(
    input logic       aclk,
    input logic       resetn,
    input addr_t      ar_addr,
    input logic       ar_valid,
    input logic       ar_ready,
    input logic       r_ready,
    input pixel_out_t pixel,
    input logic       pixel_valid,
    input logic       pixel_ready
);

    int violations = 0;

    // Address holds while the slave stalls
    ar_addr_stable: assert property (@(posedge aclk) disable iff (!resetn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else
    begin
        violations++;
        $error("ar_addr changed or ar_valid dropped before ar_ready");
    end

    // Output pixel holds under back-pressure
    pixel_stable: assert property (@(posedge aclk) disable iff (!resetn)
        pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel))
    else
    begin
        violations++;
        $error("pixel changed or pixel_valid dropped before pixel_ready");
    end

    // First cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge aclk)
        resetn && !$past(resetn) |-> !ar_valid && !pixel_valid && !r_ready)
    else
    begin
        violations++;
        $error("Valid or ready high in the cycle after reset");
    end

endmodule

bind pixel_fetch_top pixel_fetch_sva pixel_fetch_sva_i (
    .aclk        (aclk),
    .resetn      (resetn),
    .ar_addr     (ar_addr),
    .ar_valid    (ar_valid),
    .ar_ready    (ar_ready),
    .r_ready     (r_ready),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .pixel_ready (pixel_ready)
);

/* test/pixel_fetch_tb.sv */
/*
 * Pixel fetch testbench
 * Drives fragment streams with LFSR back-pressure, models the read
 * channels and checks every pixel and read address against the rules
 */
`timescale 1ns/1ps

module pixel_fetch_tb import pixel_fetch_pkg::*;;

    localparam int    CLK_PERIOD   = 10;
    localparam int    DIRECTED     = 7;
    localparam int    STALL_END    = 160;
    localparam int    NUM_FRAGS    = 320;
    localparam int    WORST_CYCLES = 100;
    localparam int    TIMEOUT_NS   = (NUM_FRAGS * WORST_CYCLES + 100) * CLK_PERIOD;
    localparam addr_t CONF_BASE    = 32'h4000_1000;

    logic aclk = 1'b0;
    logic resetn;
    addr_t conf_addr;
    frag_t frag;
    logic frag_valid, frag_ready;
    addr_t ar_addr;
    logic ar_valid, ar_ready;
    beat_t r_data;
    logic r_valid, r_ready;
    pixel_out_t pixel;
    logic pixel_valid, pixel_ready;

    // Stimulus tables and scoreboard state
    int dir_idx [DIRECTED] = '{20, 21, 20, 21, 21, 40, 41};
    bit dir_last [DIRECTED] = '{0, 0, 0, 1, 0, 0, 1};
    pix_index_t frag_idx [NUM_FRAGS];
    logic frag_lst [NUM_FRAGS];
    logic [31:0] lfsr_state;
    int exp_q [$];
    addr_t exp_addr_q [$];
    addr_t mem_addr_q [$];
    int next_frag, done_count, ar_count, req_expected, mode, stall_left, mem_wait, cmp_frag;

    pixel_fetch_top pixel_fetch_top_i (.*);

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // One bit per LFSR step with taps 32 22 2 1
    function automatic int next_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            value = (value << 1) | lfsr_state[0];
        end
        return value;
    endfunction

    // Memory contents where every address bit mixes into the beat
    function automatic beat_t beat_for_addr(input addr_t addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    // Beat address of an index
    function automatic addr_t line_addr(input pix_index_t index);
        return CONF_BASE + (index >> SLOT_WIDTH) * (2 ** BEAT_BYTES_LG);
    endfunction

    function automatic pixel_t ref_pixel(input pix_index_t index);
        beat_t beat;
        int slot;
        beat = beat_for_addr(line_addr(index));
        slot = index % PIX_PER_BEAT;
        return beat[slot * PIXEL_WIDTH +: PIXEL_WIDTH];
    endfunction

    // Request rule over the whole stream that also fills the address list
    function automatic int count_requests();
        tag_t last_tag;
        tag_t tag;
        int n;
        last_tag = '1;
        n = 0;
        for (int k = 0; k < NUM_FRAGS; k++)
        begin
            tag = frag_idx[k] >> SLOT_WIDTH;
            if (tag != last_tag)
            begin
                n++;
                exp_addr_q.push_back(line_addr(frag_idx[k]));
            end
            last_tag = frag_lst[k] ? '1 : tag;
        end
        return n;
    endfunction

    function automatic int phase_of(input int k);
        return (k < DIRECTED) ? 0 : (k < STALL_END) ? 1 : 2;
    endfunction

    function automatic string test_name(input int k);
        case (phase_of(k))
            0: return "same_beat_and_last";
            1: return "ar_stall_skid";
            default: return "random_backpressure";
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Run stopped on failure");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("** Error [%s] expected %0h actual %0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // Directed head followed by same-tag runs with random jumps
    task automatic build_fragments();
        int run_left;
        int run_tag;
        run_left = 0;
        run_tag = 0;
        for (int k = 0; k < NUM_FRAGS; k++)
        begin
            if (k < DIRECTED)
            begin
                frag_idx[k] = dir_idx[k];
                frag_lst[k] = dir_last[k];
            end
            else
            begin
                if (run_left == 0)
                begin
                    run_tag = next_bits(12);
                    run_left = 1 + next_bits(3);
                end
                frag_idx[k] = pix_index_t'(run_tag * PIX_PER_BEAT + next_bits(SLOT_WIDTH));
                frag_lst[k] = next_bits(3) == 0;
                run_left--;
            end
        end
    endtask

    ////////////////////////////////////////
    // Stimulus and memory model
    ////////////////////////////////////////
    always @(posedge aclk)
    begin
        if (resetn)
        begin
            mode = phase_of(next_frag);
            if (frag_valid && frag_ready)
            begin
                exp_q.push_back(next_frag);
                next_frag++;
            end
            // Offer the next fragment once the last one is taken
            if (!frag_valid || frag_ready)
            begin
                if (next_frag < NUM_FRAGS && (mode == 0 || next_bits(2) != 0))
                begin
                    frag <= '{index: frag_idx[next_frag], last: frag_lst[next_frag]};
                    frag_valid <= 1'b1;
                end
                else
                    frag_valid <= 1'b0;
            end
            if (ar_valid && ar_ready)
            begin
                if (ar_count >= exp_addr_q.size())
                    report_failure("More read addresses issued than the request rule allows");
                else
                    check("read_address", exp_addr_q[ar_count], ar_addr);
                ar_count++;
                mem_addr_q.push_back(ar_addr);
            end
            // Back-pressure per phase
            case (mode)
                0:
                begin
                    ar_ready <= 1'b1;
                    pixel_ready <= 1'b1;
                end
                1:
                begin
                    // Long low stretches with short high ones
                    if (stall_left == 0)
                    begin
                        ar_ready <= !ar_ready;
                        stall_left = ar_ready ? 16 + next_bits(5) : 1 + next_bits(2);
                    end
                    else
                        stall_left--;
                    pixel_ready <= next_bits(3) != 0;
                end
                default:
                begin
                    ar_ready <= next_bits(2) != 0;
                    pixel_ready <= next_bits(1);
                end
            endcase
            // In-order single-beat returns with random latency
            if (r_valid && r_ready)
                r_valid <= 1'b0;
            if ((!r_valid || r_ready) && mem_addr_q.size() != 0)
            begin
                if (mem_wait == 0)
                begin
                    r_data <= beat_for_addr(mem_addr_q.pop_front());
                    r_valid <= 1'b1;
                    mem_wait = (mode == 2) ? next_bits(2) : 0;
                end
                else
                    mem_wait--;
            end
        end
    end

    ////////////////////////////////////////
    // Output compare
    ////////////////////////////////////////
    always @(posedge aclk)
    begin
        if (pixel_fetch_top_i.pixel_fetch_sva_i.violations != 0)
            report_failure("Bound handshake assertion failed");
        if (resetn && pixel_valid && pixel_ready)
        begin
            if (exp_q.size() == 0)
                report_failure("Pixel came out with no fragment accepted for it");
            else
            begin
                cmp_frag = exp_q.pop_front();
                check(test_name(cmp_frag), ref_pixel(frag_idx[cmp_frag]), pixel.pixel);
                check({test_name(cmp_frag), "_last"}, frag_lst[cmp_frag], pixel.last);
                done_count++;
            end
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout, only %0d of %0d pixels arrived", done_count, NUM_FRAGS);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        resetn = 1'b0;
        conf_addr = CONF_BASE;
        frag = '0;
        frag_valid = 1'b0;
        ar_ready = 1'b0;
        r_data = '0;
        r_valid = 1'b0;
        pixel_ready = 1'b0;
        lfsr_state = 32'hb02a;
        build_fragments();
        req_expected = count_requests();
        repeat (2) @(posedge aclk);
        resetn <= 1'b1;
        while (done_count < NUM_FRAGS)
            @(posedge aclk);
        // Room for any stray pixel or address
        repeat (20) @(posedge aclk);
        check("request_count", req_expected, ar_count);
        check("frag_ready_recovered", 1, frag_ready);
        if (pixel_fetch_top_i.pixel_fetch_sva_i.violations == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("Bound handshake assertions failed");
            $display("TEST FAILED");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

/* build.f */
src/pixel_fetch_pkg.sv
src/fetch_request_gen.sv
src/fragment_queue.sv
src/pixel_select.sv
src/pixel_fetch_top.sv
test/pixel_fetch_sva.sv
test/pixel_fetch_tb.sv

/* Bender.yml */
package:
  name: pixel_fetch

sources:
  - files:
      - src/pixel_fetch_pkg.sv
      - src/fetch_request_gen.sv
      - src/fragment_queue.sv
      - src/pixel_select.sv
      - src/pixel_fetch_top.sv

  - target: test
    files:
      - test/pixel_fetch_sva.sv
      - test/pixel_fetch_tb.sv
